/* hdl/can_cfg_pkg.sv */
package can_cfg_pkg;

  typedef logic [4:0]  reg_addr_t;  // Controller register address
  typedef logic [15:0] reg_word_t;  // Controller register word
  typedef logic [75:0] can_msg_t;   // Bit 75 spare, 74:64 ID, 63:0 data

  typedef enum logic [1:0] {
    cmd_init,
    cmd_send,
    cmd_trim,
    cmd_bus_reset
  } cfg_cmd_e;

  // Transmit buffer registers
  localparam reg_addr_t addr_tx_id   = 5'h0C;
  localparam reg_addr_t addr_tx_d12  = 5'h0A;
  localparam reg_addr_t addr_tx_d34  = 5'h09;
  localparam reg_addr_t addr_tx_d56  = 5'h08;
  localparam reg_addr_t addr_tx_d78  = 5'h07;

  // Control registers
  localparam reg_addr_t addr_general = 5'h0E;
  localparam reg_addr_t addr_tx_ctrl = 5'h0D;
  localparam reg_addr_t addr_irq     = 5'h12;

  localparam reg_word_t gen_word       = 16'h009C;
  localparam reg_word_t tx_ctrl_word   = 16'h8008;  // Transmit request
  localparam reg_word_t irq_reset_word = 16'h8070;

  // Message with the most transitions on the bus
  localparam can_msg_t trim_msg = {12'h555, 64'hAAAA_AAAA_AAAA_AAAA};

  // Write list lengths
  localparam int msg_steps = 7;  // Send and trim
  localparam int irq_steps = 2;  // Bus reset

  localparam int step_w = $clog2(msg_steps);
  typedef logic [step_w-1:0] step_t;

  // Write buffer
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;
  typedef logic [fifo_ptr_w:0]   fifo_cnt_t;  // One bit wider to hold a full count

endpackage

/* hdl/can_word_formatter.sv */
`timescale 1ns/10ps
module can_word_formatter import can_cfg_pkg::*; (
  input  reg_addr_t addr,
  input  can_msg_t  msg,
  input  logic      use_trim,
  output reg_word_t word
);

  can_msg_t sel_msg;

  assign sel_msg = use_trim ? trim_msg : msg;  // Trim replaces host message

  always_comb begin
    word = '0;
    case (addr)
      addr_tx_id: begin
        word[15:5] = sel_msg[74:64];  // Standard identifier
        word[4:0]  = 5'h00;
      end

      addr_tx_d12: begin
        word[15:8] = sel_msg[63:56];
        word[7:0]  = sel_msg[47:40];
      end

      addr_tx_d34: begin
        word[15:8] = sel_msg[55:48];
        word[7:0]  = sel_msg[39:32];
      end

      // Upper data bytes come from the low end of the message
      addr_tx_d56: begin
        word[15:8] = sel_msg[7:0];
        word[7:0]  = sel_msg[15:8];
      end

      addr_tx_d78: begin
        word[15:8] = sel_msg[23:16];
        word[7:0]  = sel_msg[31:24];
      end

      addr_general: begin
        word = gen_word;
      end

      addr_tx_ctrl: begin
        word = tx_ctrl_word;
      end

      addr_irq: begin
        word = irq_reset_word;  // Clear pending bus interrupts
      end

      default: begin
        word = '0;
      end
    endcase
  end

endmodule

/* hdl/can_cfg_sequencer.sv */
`timescale 1ns/10ps
module can_cfg_sequencer import can_cfg_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      cmd_valid,
  input  cfg_cmd_e  cmd_op,
  input  can_msg_t  cmd_msg,
  input  reg_addr_t cmd_addr,
  input  reg_word_t cmd_word,
  output logic      cmd_ready,
  output logic      push,
  output reg_addr_t push_addr,
  output reg_word_t push_word,
  input  logic      full
);

  typedef enum logic {
    idle,
    run
  } seq_state_e;

  seq_state_e state;
  cfg_cmd_e   lat_op;
  can_msg_t   lat_msg;
  reg_addr_t  lat_addr;
  reg_word_t  lat_word;
  step_t      step;
  step_t      last_step;
  reg_addr_t  list_addr;
  reg_word_t  fmt_word;

  assign cmd_ready = (state == idle);
  assign push      = (state == run) && !full;  // Stall on a full buffer
  assign push_addr = list_addr;
  assign push_word = (lat_op == cmd_init) ? lat_word : fmt_word;

  // Address list per command
  always_comb begin
    list_addr = lat_addr;
    last_step = '0;
    case (lat_op)
      cmd_send, cmd_trim: begin
        last_step = step_t'(msg_steps - 1);
        case (step)
          step_t'(0): list_addr = addr_tx_id;
          step_t'(1): list_addr = addr_tx_d12;
          step_t'(2): list_addr = addr_tx_d34;
          step_t'(3): list_addr = addr_tx_d56;
          step_t'(4): list_addr = addr_tx_d78;
          step_t'(5): list_addr = addr_general;
          default:    list_addr = addr_tx_ctrl;  // Starts transmission
        endcase
      end
      cmd_bus_reset: begin
        last_step = step_t'(irq_steps - 1);
        list_addr = (step == '0) ? addr_general : addr_irq;
      end
      default: begin
        list_addr = lat_addr;  // Direct register write
      end
    endcase
  end

  can_word_formatter i_can_word_formatter (
    .addr     (list_addr),
    .msg      (lat_msg),
    .use_trim (lat_op == cmd_trim),
    .word     (fmt_word)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
      step  <= '0;
    end else begin
      case (state)
        idle: begin
          if (cmd_valid) begin
            state <= run;
            step  <= '0;
          end
        end
        run: begin
          if (push) begin
            if (step == last_step) begin
              state <= idle;  // Ready again next cycle
            end else begin
              step <= step + 1'b1;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (cmd_valid && cmd_ready) begin
      lat_op   <= cmd_op;
      lat_msg  <= cmd_msg;
      lat_addr <= cmd_addr;
      lat_word <= cmd_word;
    end
  end

  // Step counter stays inside the command's write list
  a_step_in_list: assert property (@(posedge clock) disable iff (reset)
    state == run |-> step <= last_step)
    else $error("sequencer step ran past the end of its write list");

endmodule

/* hdl/can_write_fifo.sv */
`timescale 1ns/10ps
module can_write_fifo import can_cfg_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      push,
  input  reg_addr_t push_addr,
  input  reg_word_t push_word,
  input  logic      pop,
  output logic      full,
  output logic      empty,
  output reg_addr_t head_addr,
  output reg_word_t head_word
);

  reg_addr_t addr_mem [fifo_depth];
  reg_word_t word_mem [fifo_depth];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_cnt_t count;

  assign full      = (count == fifo_cnt_t'(fifo_depth));
  assign empty     = (count == '0);
  assign head_addr = addr_mem[rd_ptr];
  assign head_word = word_mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      addr_mem[wr_ptr] <= push_addr;
      word_mem[wr_ptr] <= push_word;
    end
  end

  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    push |-> !full)
    else $error("write FIFO overflow");

  a_no_underflow: assert property (@(posedge clock) disable iff (reset)
    pop |-> !empty)
    else $error("write FIFO underflow");

endmodule

/* hdl/can_wb_master.sv */
`timescale 1ns/10ps
module can_wb_master import can_cfg_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      empty,
  input  reg_addr_t head_addr,
  input  reg_word_t head_word,
  output logic      pop,
  output logic      wb_cyc,
  output logic      wb_stb,
  output logic      wb_we,
  output reg_addr_t wb_adr,
  output reg_word_t wb_dat_o,
  input  logic      wb_ack,
  output logic      active
);

  typedef enum logic {
    idle,
    cycle
  } wb_state_e;

  wb_state_e state;

  assign wb_cyc = (state == cycle);
  assign wb_stb = (state == cycle);
  assign wb_we  = (state == cycle);  // Writes only
  assign active = (state == cycle);
  assign pop    = (state == cycle) && wb_ack;  // Retire head on ack

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle:    if (!empty) state <= cycle;
        cycle:   if (wb_ack) state <= idle;  // At least one idle cycle follows
        default: state <= idle;
      endcase
    end
  end

  // Bus holds a copy of the head for the whole cycle
  always_ff @(posedge clock) begin
    if (state == idle && !empty) begin
      wb_adr   <= head_addr;
      wb_dat_o <= head_word;
    end
  end

  a_idle_gap: assert property (@(posedge clock) disable iff (reset)
    wb_cyc && wb_ack |=> !wb_cyc)
    else $error("no idle cycle between Wishbone cycles");

  a_bus_stable: assert property (@(posedge clock) disable iff (reset)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_o))
    else $error("Wishbone cycle changed before ack");

endmodule

/* hdl/can_cfg_top.sv */
`timescale 1ns/10ps
module can_cfg_top import can_cfg_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      cmd_valid,
  input  cfg_cmd_e  cmd_op,
  input  can_msg_t  cmd_msg,
  input  reg_addr_t cmd_addr,
  input  reg_word_t cmd_word,
  output logic      cmd_ready,
  output logic      wb_cyc,
  output logic      wb_stb,
  output logic      wb_we,
  output reg_addr_t wb_adr,
  output reg_word_t wb_dat_o,
  input  logic      wb_ack,
  output logic      busy
);

  logic      push;
  reg_addr_t push_addr;
  reg_word_t push_word;
  logic      full;
  logic      empty;
  reg_addr_t head_addr;
  reg_word_t head_word;
  logic      pop;
  logic      wb_active;

  // Sequencer is active whenever it refuses commands
  assign busy = !cmd_ready || !empty || wb_active;

  can_cfg_sequencer i_can_cfg_sequencer (
    .clock     (clock),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_msg   (cmd_msg),
    .cmd_addr  (cmd_addr),
    .cmd_word  (cmd_word),
    .cmd_ready (cmd_ready),
    .push      (push),
    .push_addr (push_addr),
    .push_word (push_word),
    .full      (full)
  );

  can_write_fifo i_can_write_fifo (
    .clock     (clock),
    .reset     (reset),
    .push      (push),
    .push_addr (push_addr),
    .push_word (push_word),
    .pop       (pop),
    .full      (full),
    .empty     (empty),
    .head_addr (head_addr),
    .head_word (head_word)
  );

  can_wb_master i_can_wb_master (
    .clock     (clock),
    .reset     (reset),
    .empty     (empty),
    .head_addr (head_addr),
    .head_word (head_word),
    .pop       (pop),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .active    (wb_active)
  );

endmodule

/* tests/can_cfg_tb.sv */
`timescale 1ns/10ps
module can_cfg_tb import can_cfg_pkg::*; ();

  typedef logic [20:0] wr_entry_t;  // {address, word}

  localparam int wait_limit = 400;

  logic      clock;
  logic      reset;
  logic      cmd_valid;
  cfg_cmd_e  cmd_op;
  can_msg_t  cmd_msg;
  reg_addr_t cmd_addr;
  reg_word_t cmd_word;
  logic      cmd_ready;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  reg_addr_t wb_adr;
  reg_word_t wb_dat_o;
  logic      wb_ack;
  logic      busy;

  integer    seed = 10;
  logic      slow_ack;
  wr_entry_t obs_q[$];
  wr_entry_t exp_q[$];
  int        err_count;
  int        bus_errors;
  int        errs_at_start;
  int        tests_run;
  int        tests_passed;
  can_msg_t  msg_a;
  can_msg_t  msg_b;

  can_cfg_top i_can_cfg_top (
    .clock     (clock),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_msg   (cmd_msg),
    .cmd_addr  (cmd_addr),
    .cmd_word  (cmd_word),
    .cmd_ready (cmd_ready),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .busy      (busy)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;  // 20 ns period
  end

  // Register bank model, acks each strobe after 0 to 5 cycles
  initial begin
    int  wait_left;
    bit  in_cycle;
    wb_ack    = 1'b0;
    wait_left = 0;
    in_cycle  = 1'b0;
    forever begin
      @(posedge clock);
      #2;
      if (wb_ack) begin
        wb_ack = 1'b0;  // Master closed the cycle on this edge
      end else if (wb_stb) begin
        if (!in_cycle) begin
          in_cycle  = 1'b1;
          wait_left = slow_ack ? 5 : $unsigned($random(seed)) % 6;
        end
        if (wait_left == 0) begin
          wb_ack   = 1'b1;
          in_cycle = 1'b0;
          obs_q.push_back({wb_adr, wb_dat_o});
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

  a_cyc_with_stb: assert property (@(posedge clock) disable iff (reset) wb_cyc == wb_stb)
    else begin
      bus_errors = bus_errors + 1;
      $display("Bus rule broken: wb_cyc and wb_stb differ at %0t", $time);
    end

  a_write_only: assert property (@(posedge clock) disable iff (reset) wb_cyc |-> wb_we)
    else begin
      bus_errors = bus_errors + 1;
      $display("Bus rule broken: cycle without wb_we at %0t", $time);
    end

  a_hold_until_ack: assert property (@(posedge clock) disable iff (reset)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_o))
    else begin
      bus_errors = bus_errors + 1;
      $display("Bus rule broken: cycle changed before ack at %0t", $time);
    end

  a_busy_while_seq: assert property (@(posedge clock) disable iff (reset) !cmd_ready |-> busy)
    else begin
      bus_errors = bus_errors + 1;
      $display("Status rule broken: busy low while commands refused at %0t", $time);
    end

  task automatic random_msg(output can_msg_t msg);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    r0  = $random(seed);
    r1  = $random(seed);
    r2  = $random(seed);
    msg = {r2[11:0], r1, r0};
  endtask

  task automatic issue(input cfg_cmd_e op, input can_msg_t msg, input reg_addr_t addr,
                       input reg_word_t word);
    int cycles;
    cycles = 0;
    while (!cmd_ready && cycles < wait_limit) begin
      @(posedge clock);
      #2;
      cycles++;
    end
    if (!cmd_ready) begin
      $display("Timeout: cmd_ready stayed low for %0d cycles", wait_limit);
      err_count++;
    end else begin
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_msg   = msg;
      cmd_addr  = addr;
      cmd_word  = word;
      @(posedge clock);
      #2;
      cmd_valid = 1'b0;
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy && cycles < wait_limit) begin
      @(posedge clock);
      #2;
      cycles++;
    end
    if (busy) begin
      $display("Timeout: busy stayed high for %0d cycles", wait_limit);
      err_count++;
    end
  endtask

  // Expected send sequence straight from the field mapping
  task automatic expect_send(input can_msg_t m);
    exp_q.push_back({addr_tx_id, m[74:64], 5'b00000});
    exp_q.push_back({addr_tx_d12, m[63:56], m[47:40]});
    exp_q.push_back({addr_tx_d34, m[55:48], m[39:32]});
    exp_q.push_back({addr_tx_d56, m[7:0], m[15:8]});
    exp_q.push_back({addr_tx_d78, m[23:16], m[31:24]});
    exp_q.push_back({addr_general, gen_word});
    exp_q.push_back({addr_tx_ctrl, tx_ctrl_word});
  endtask

  task automatic start_test();
    obs_q.delete();
    exp_q.delete();
    errs_at_start = err_count + bus_errors;
  endtask

  task automatic check_value(input string name, input string what, input int expected,
                             input int actual);
    assert (actual == expected)
      else begin
        $display("[ERROR] %s: %s expected %0d actual %0d", name, what, expected, actual);
        err_count++;
      end
  endtask

  task automatic finish_test(input string name, input bit compare);
    int n;
    int i;
    if (compare) begin
      check_value(name, "write count", exp_q.size(), obs_q.size());
      n = (obs_q.size() < exp_q.size()) ? obs_q.size() : exp_q.size();
      for (i = 0; i < n; i++) begin
        assert (obs_q[i] === exp_q[i])
          else begin
            $display("[ERROR] %s: write %0d expected %h:%h actual %h:%h", name, i,
                     exp_q[i][20:16], exp_q[i][15:0], obs_q[i][20:16], obs_q[i][15:0]);
            err_count++;
          end
      end
    end
    tests_run++;
    if (err_count + bus_errors == errs_at_start) begin
      tests_passed++;
      $display("test %s: PASS", name);
    end else begin
      $display("test %s: FAIL", name);
    end
  endtask

  initial begin
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd_op    = cmd_init;
    cmd_msg   = '0;
    cmd_addr  = '0;
    cmd_word  = '0;
    slow_ack  = 1'b0;
    err_count = 0;
    bus_errors = 0;
    tests_run = 0;
    tests_passed = 0;
    repeat (16) @(posedge clock);
    #2;
    reset = 1'b0;

    start_test();
    check_value("reset", "wb_cyc", 0, int'(wb_cyc));
    check_value("reset", "wb_stb", 0, int'(wb_stb));
    check_value("reset", "busy", 0, int'(busy));
    check_value("reset", "cmd_ready", 1, int'(cmd_ready));
    finish_test("reset", 1'b0);

    start_test();
    issue(cmd_init, '0, 5'h05, 16'hC3A5);
    exp_q.push_back({5'h05, 16'hC3A5});
    wait_idle();
    finish_test("init", 1'b1);

    start_test();
    random_msg(msg_a);
    issue(cmd_send, msg_a, '0, '0);
    expect_send(msg_a);
    wait_idle();
    finish_test("send", 1'b1);

    start_test();
    random_msg(msg_a);  // Ignored by the DUT
    issue(cmd_trim, msg_a, '0, '0);
    exp_q.push_back({addr_tx_id, 16'hAAA0});
    exp_q.push_back({addr_tx_d12, 16'hAAAA});
    exp_q.push_back({addr_tx_d34, 16'hAAAA});
    exp_q.push_back({addr_tx_d56, 16'hAAAA});
    exp_q.push_back({addr_tx_d78, 16'hAAAA});
    exp_q.push_back({addr_general, gen_word});
    exp_q.push_back({addr_tx_ctrl, tx_ctrl_word});
    wait_idle();
    finish_test("trim", 1'b1);

    start_test();
    issue(cmd_bus_reset, '0, '0, '0);
    exp_q.push_back({addr_general, gen_word});
    exp_q.push_back({addr_irq, irq_reset_word});
    wait_idle();
    finish_test("bus_reset", 1'b1);

    // Slowest ack fills the FIFO and stalls the second command
    start_test();
    slow_ack = 1'b1;
    random_msg(msg_a);
    random_msg(msg_b);
    issue(cmd_send, msg_a, '0, '0);
    issue(cmd_send, msg_b, '0, '0);
    expect_send(msg_a);
    expect_send(msg_b);
    wait_idle();
    slow_ack = 1'b0;
    finish_test("back_pressure", 1'b1);

    $display("Tests run: %0d, passed: %0d, failed: %0d, bus rule violations: %0d",
             tests_run, tests_passed, tests_run - tests_passed, bus_errors);
    if (err_count == 0 && bus_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* compile.f */
hdl/can_cfg_pkg.sv
hdl/can_word_formatter.sv
hdl/can_cfg_sequencer.sv
hdl/can_write_fifo.sv
hdl/can_wb_master.sv
hdl/can_cfg_top.sv
tests/can_cfg_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the CAN configuration testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module can_cfg_tb -o can_cfg_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/can_cfg_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
  exit 0
else
  exit 1
fi
